// ==== Bender.yml ====
package:
  name: serv_core

sources:
  - hdl/serv_isa_pkg.sv
  - hdl/serv_bus_pkg.sv
  - hdl/serv_state.sv
  - hdl/serv_decode.sv
  - hdl/serv_alu.sv
  - hdl/serv_rf.sv
  - hdl/serv_ctrl.sv
  - hdl/serv_lsu.sv
  - hdl/serv_top.sv
  - target: test
    files:
      - verif/serv_tb.sv

// ==== hdl/serv_alu.sv ====
`timescale 1ns/1ps

module serv_alu import serv_isa_pkg::*; (
   input  logic    clk,
   input  logic    i_rst_n,
   input  logic    i_cnt_en,
   input  logic    i_cnt_done,
   input  alu_op_e i_op,
   input  logic    i_rs1,
   input  logic    i_op_b,
   output logic    o_rd,
   output logic    o_eq
);

   logic first_q;
   logic carry_q;
   logic eq_q;
   logic b_eff;
   logic cin;
   logic sum;

   // Two's complement subtract: invert B, carry in of one
   assign b_eff = (i_op == ALU_SUB) ? ~i_op_b : i_op_b;
   assign cin   = first_q ? (i_op == ALU_SUB) : carry_q;
   assign sum   = i_rs1 ^ b_eff ^ cin;
   assign o_eq  = (first_q || eq_q) && (i_rs1 == i_op_b);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         first_q <= 1'b1;
         carry_q <= 1'b0;
         eq_q    <= 1'b1;
      end else begin
         first_q <= !i_cnt_en || i_cnt_done;
         if (i_cnt_en) begin
            carry_q <= (i_rs1 & b_eff) | (cin & (i_rs1 ^ b_eff));
            eq_q    <= o_eq;
         end
      end
   end

   always_comb begin
      case (i_op)
         ALU_AND:    o_rd = i_rs1 & i_op_b;
         ALU_OR:     o_rd = i_rs1 | i_op_b;
         ALU_XOR:    o_rd = i_rs1 ^ i_op_b;
         ALU_PASS_B: o_rd = i_op_b;
         default:    o_rd = sum;
      endcase
   end

endmodule

// ==== hdl/serv_bus_pkg.sv ====
package serv_bus_pkg;

   // Instruction fetch request, held until ack
   typedef struct packed {
      logic [31:0] adr;
      logic        cyc;
   } ibus_req_t;

   // Write-only data bus, stores are always full words
   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic        cyc;
   } dbus_req_t;

endpackage

// ==== hdl/serv_ctrl.sv ====
`timescale 1ns/1ps

module serv_ctrl import serv_isa_pkg::*, serv_bus_pkg::*; #(
   parameter logic [31:0] RESET_PC = 32'h0
) (
   input  logic      clk,
   input  logic      i_rst_n,
   input  phase_e    i_phase,
   input  logic      i_cnt_en,
   input  logic      i_cnt_done,
   input  logic      i_imm,
   input  decode_t   i_dec,
   input  logic      i_eq,
   output logic      o_link,
   output ibus_req_t o_ibus
);

   logic [31:0] pc_q;
   logic [2:0]  pos_q;
   logic        c4_q;
   logic        ci_q;
   logic        taken_q;
   logic        run_q;
   logic        pass_end;
   logic        pc_bit;
   logic        four_bit;
   logic        sumi;
   logic        new_bit;

   assign pass_end = !i_cnt_en || i_cnt_done;
   assign pc_bit   = pc_q[0];
   // Marks bit 2, the only set bit of the constant 4
   assign four_bit = pos_q[2];
   assign o_link   = pc_bit ^ four_bit ^ c4_q;
   assign sumi     = pc_bit ^ i_imm ^ ci_q;

   assign o_ibus.adr = pc_q;
   assign o_ibus.cyc = run_q && (i_phase == PH_FETCH);

   always_comb begin
      if (i_phase == PH_BRANCH) begin
         new_bit = taken_q ? sumi : o_link;
      end else if (i_dec.is_branch) begin
         new_bit = pc_bit;  // keep the PC for the branch pass
      end else if (i_dec.is_jal) begin
         new_bit = sumi;
      end else begin
         new_bit = o_link;
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc_q    <= RESET_PC;
         pos_q   <= 3'b001;
         c4_q    <= 1'b0;
         ci_q    <= 1'b0;
         taken_q <= 1'b0;
         run_q   <= 1'b0;
      end else begin
         run_q <= 1'b1;
         if (i_cnt_en) begin
            pc_q <= {new_bit, pc_q[31:1]};
         end
         if (pass_end) begin
            pos_q <= 3'b001;
            c4_q  <= 1'b0;
            ci_q  <= 1'b0;
         end else begin
            pos_q <= {pos_q[1:0], 1'b0};
            c4_q  <= (pc_bit & four_bit) | (c4_q & (pc_bit ^ four_bit));
            ci_q  <= (pc_bit & i_imm) | (ci_q & (pc_bit ^ i_imm));
         end
         if (i_phase == PH_EXEC && i_cnt_done) begin
            taken_q <= i_eq ^ i_dec.branch_ne;
         end
      end
   end

endmodule

// ==== hdl/serv_decode.sv ====
`timescale 1ns/1ps

module serv_decode import serv_isa_pkg::*; (
   input  logic        clk,
   input  logic        i_rst_n,
   input  logic [31:0] i_ibus_rdt,
   input  logic        i_ibus_ack,
   input  logic        i_cnt_en,
   output decode_t     o_dec,
   output logic        o_imm
);

   logic [31:0] ir;
   logic [31:0] imm_sr;
   logic        wr;

   function automatic logic [31:0] form_imm(input logic [31:0] w);
      case (w[6:0])
         OPC_STORE:  form_imm = {{21{w[31]}}, w[30:25], w[11:7]};
         OPC_BRANCH: form_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
         OPC_LUI:    form_imm = {w[31:12], 12'd0};
         OPC_JAL:    form_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         default:    form_imm = {{21{w[31]}}, w[30:20]};
      endcase
   endfunction

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         ir <= 32'd0;
      end else if (i_ibus_ack) begin
         ir <= i_ibus_rdt;
      end
   end

   // Rotating, so the branch pass sees the immediate again
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_sr <= form_imm(i_ibus_rdt);
      end else if (i_cnt_en) begin
         imm_sr <= {imm_sr[0], imm_sr[31:1]};
      end
   end

   assign o_imm = imm_sr[0];

   always_comb begin
      o_dec          = '0;
      o_dec.rd_addr  = ir[11:7];
      o_dec.rs1_addr = ir[19:15];
      o_dec.rs2_addr = ir[24:20];
      o_dec.alu_op   = ALU_ADD;
      wr             = 1'b0;
      case (ir[6:0])
         OPC_OP: begin
            if (ir[31:25] == 7'h00 || (ir[31:25] == 7'h20 && ir[14:12] == 3'b000)) begin
               wr = 1'b1;
               case (ir[14:12])
                  3'b000:  o_dec.alu_op = ir[30] ? ALU_SUB : ALU_ADD;
                  3'b100:  o_dec.alu_op = ALU_XOR;
                  3'b110:  o_dec.alu_op = ALU_OR;
                  3'b111:  o_dec.alu_op = ALU_AND;
                  default: wr = 1'b0;
               endcase
            end
         end
         OPC_OP_IMM: begin
            o_dec.op_b_imm = 1'b1;
            wr             = (ir[14:12] == 3'b000);
         end
         OPC_LUI: begin
            o_dec.op_b_imm = 1'b1;
            o_dec.alu_op   = ALU_PASS_B;
            wr             = 1'b1;
         end
         OPC_STORE: begin
            o_dec.op_b_imm = 1'b1;
            o_dec.is_store = (ir[14:12] == 3'b010);
         end
         OPC_BRANCH: begin
            o_dec.is_branch = (ir[14:13] == 2'b00);
            o_dec.branch_ne = ir[12];
         end
         OPC_JAL: begin
            o_dec.is_jal = 1'b1;
            wr           = 1'b1;
         end
         default: ;
      endcase
      // x0 target turns the write off here
      o_dec.rd_en = wr && (o_dec.rd_addr != 5'd0);
   end

endmodule

// ==== hdl/serv_isa_pkg.sv ====
package serv_isa_pkg;

   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_STORE  = 7'b0100011,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_e;

   // EXEC and BRANCH are the counted passes
   typedef enum logic [1:0] {
      PH_FETCH,
      PH_EXEC,
      PH_BRANCH,
      PH_STORE
   } phase_e;

   typedef struct packed {
      logic [4:0] rd_addr;
      logic [4:0] rs1_addr;
      logic [4:0] rs2_addr;
      alu_op_e    alu_op;
      logic       op_b_imm;
      logic       rd_en;
      logic       is_store;
      logic       is_branch;
      logic       branch_ne;
      logic       is_jal;
   } decode_t;

endpackage

// ==== hdl/serv_lsu.sv ====
`timescale 1ns/1ps

module serv_lsu import serv_isa_pkg::*, serv_bus_pkg::*; (
   input  logic      clk,
   input  logic      i_rst_n,
   input  phase_e    i_phase,
   input  logic      i_cnt_en,
   input  logic      i_addr_bit,
   input  logic      i_rs2,
   input  logic      i_dbus_ack,
   output dbus_req_t o_dbus
);

   logic [31:0] adr_q;
   logic [31:0] dat_q;

   // Filled LSB first during EXEC, full by the STORE phase
   always_ff @(posedge clk) begin
      if (i_cnt_en && i_phase == PH_EXEC) begin
         adr_q <= {i_addr_bit, adr_q[31:1]};
         dat_q <= {i_rs2, dat_q[31:1]};
      end
   end

   assign o_dbus.adr = adr_q;
   assign o_dbus.dat = dat_q;
   assign o_dbus.cyc = (i_phase == PH_STORE);

   a_cyc_until_ack: assert property (@(posedge clk) disable iff (!i_rst_n)
      $fell(o_dbus.cyc) |-> $past(i_dbus_ack));

   a_req_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_dbus.cyc && !i_dbus_ack) |=> ($stable(o_dbus.adr) && $stable(o_dbus.dat)));

endmodule

// ==== hdl/serv_rf.sv ====
`timescale 1ns/1ps

module serv_rf (
   input  logic       clk,
   input  logic       i_rst_n,
   input  logic       i_cnt_en,
   input  logic [4:0] i_rs1_addr,
   input  logic [4:0] i_rs2_addr,
   input  logic [4:0] i_rd_addr,
   input  logic       i_rd_en,
   input  logic       i_rd,
   output logic       o_rs1,
   output logic       o_rs2
);

   logic [31:0] regs [1:31];
   logic [31:0] lsb;

   // Bit zero of every register, x0 reads as zero
   always_comb begin
      lsb[0] = 1'b0;
      for (int r = 1; r < 32; r++) begin
         lsb[r] = regs[r][0];
      end
   end

   assign o_rs1 = lsb[i_rs1_addr];
   assign o_rs2 = lsb[i_rs2_addr];

   // Sources rotate back into place after a full pass
   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         for (int r = 1; r < 32; r++) begin
            if (i_rd_en && i_rd_addr == 5'(r)) begin
               regs[r] <= {i_rd, regs[r][31:1]};
            end else if (i_rs1_addr == 5'(r) || i_rs2_addr == 5'(r)) begin
               regs[r] <= {regs[r][0], regs[r][31:1]};
            end
         end
      end
   end

   a_no_x0_write: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_rd_en |-> (i_rd_addr != 5'd0));

endmodule

// ==== hdl/serv_state.sv ====
`timescale 1ns/1ps

module serv_state import serv_isa_pkg::*; (
   input  logic       clk,
   input  logic       i_rst_n,
   input  logic       i_ibus_ack,
   input  logic       i_dbus_ack,
   input  decode_t    i_dec,
   output phase_e     o_phase,
   output logic [4:0] o_cnt,
   output logic       o_cnt_en,
   output logic       o_cnt_done
);

   assign o_cnt_en   = (o_phase == PH_EXEC) || (o_phase == PH_BRANCH);
   assign o_cnt_done = o_cnt_en && (o_cnt == 5'd31);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_phase <= PH_FETCH;
         o_cnt   <= 5'd0;
      end else begin
         if (o_cnt_en) begin
            o_cnt <= o_cnt + 5'd1;
         end
         unique case (o_phase)
            PH_FETCH: begin
               if (i_ibus_ack) begin
                  o_phase <= PH_EXEC;
               end
            end
            PH_EXEC: begin
               if (o_cnt_done) begin
                  if (i_dec.is_branch) begin
                     o_phase <= PH_BRANCH;
                  end else if (i_dec.is_store) begin
                     o_phase <= PH_STORE;
                  end else begin
                     o_phase <= PH_FETCH;
                  end
               end
            end
            PH_BRANCH: begin
               if (o_cnt_done) begin
                  o_phase <= PH_FETCH;
               end
            end
            PH_STORE: begin
               if (i_dbus_ack) begin
                  o_phase <= PH_FETCH;
               end
            end
         endcase
      end
   end

   // Counter rests at zero between passes
   a_idle_cnt: assert property (@(posedge clk) disable iff (!i_rst_n)
      (o_phase inside {PH_FETCH, PH_STORE}) |-> (o_cnt == 5'd0));

endmodule

// ==== hdl/serv_top.sv ====
`timescale 1ns/1ps

module serv_top import serv_isa_pkg::*, serv_bus_pkg::*; #(
   parameter logic [31:0] RESET_PC = 32'h0
) (
   input  logic        clk,
   input  logic        i_rst_n,
   input  logic [31:0] i_ibus_rdt,
   input  logic        i_ibus_ack,
   input  logic        i_dbus_ack,
   output ibus_req_t   o_ibus,
   output dbus_req_t   o_dbus
);

   phase_e  phase;
   decode_t dec;
   logic    cnt_en;
   logic    cnt_done;
   logic    ibus_ack;
   logic    dbus_ack;
   logic    imm;
   logic    rs1;
   logic    rs2;
   logic    op_b;
   logic    alu_rd;
   logic    eq;
   logic    link;
   logic    rd;

   // Ack counts only while a request is open
   assign ibus_ack = i_ibus_ack && o_ibus.cyc;
   assign dbus_ack = i_dbus_ack && o_dbus.cyc;

   assign op_b = dec.op_b_imm ? imm : rs2;
   assign rd   = dec.is_jal ? link : alu_rd;

   serv_state u_state (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (ibus_ack),
      .i_dbus_ack (dbus_ack),
      .i_dec      (dec),
      .o_phase    (phase),
      .o_cnt      (),
      .o_cnt_en   (cnt_en),
      .o_cnt_done (cnt_done)
   );

   serv_decode u_decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .i_cnt_en   (cnt_en),
      .o_dec      (dec),
      .o_imm      (imm)
   );

   serv_rf u_rf (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_rs1_addr (dec.rs1_addr),
      .i_rs2_addr (dec.rs2_addr),
      .i_rd_addr  (dec.rd_addr),
      .i_rd_en    (dec.rd_en),
      .i_rd       (rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   serv_alu u_alu (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_cnt_done (cnt_done),
      .i_op       (dec.alu_op),
      .i_rs1      (rs1),
      .i_op_b     (op_b),
      .o_rd       (alu_rd),
      .o_eq       (eq)
   );

   serv_ctrl #(
      .RESET_PC (RESET_PC)
   ) u_ctrl (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_phase    (phase),
      .i_cnt_en   (cnt_en),
      .i_cnt_done (cnt_done),
      .i_imm      (imm),
      .i_dec      (dec),
      .i_eq       (eq),
      .o_link     (link),
      .o_ibus     (o_ibus)
   );

   serv_lsu u_lsu (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_phase    (phase),
      .i_cnt_en   (cnt_en),
      .i_addr_bit (alu_rd),
      .i_rs2      (rs2),
      .i_dbus_ack (dbus_ack),
      .o_dbus     (o_dbus)
   );

endmodule

// ==== verif/serv_tb.sv ====
`timescale 1ns/1ps

module serv_tb import serv_isa_pkg::*, serv_bus_pkg::*;;

   localparam logic [31:0] RESET_PC = 32'h0000_0100;
   localparam logic [31:0] HALT     = 32'h0000_006f;

   logic        clk = 1'b0;
   logic        i_rst_n;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic        i_dbus_ack;
   ibus_req_t   o_ibus;
   dbus_req_t   o_dbus;

   logic [31:0] imem [0:127];
   logic [31:0] xreg [0:31];
   string       test_name [0:7];
   int          test_start [0:7];
   int          n_words = 0;
   int          n_tests = 0;
   int          cur_test = 0;
   int          errors = 0;
   int          checks = 0;
   int          err_mark = 0;
   int          ib_delay = -1;
   int          db_delay = -1;
   integer      seed;
   logic        built = 1'b0;
   logic        done = 1'b0;
   logic [31:0] ref_pc = RESET_PC;
   logic        store_pend = 1'b0;
   dbus_req_t   exp_st;
   ibus_req_t   exp_ib;
   ibus_req_t   prev_ib;
   dbus_req_t   prev_db;
   logic        ib_hold = 1'b0;
   logic        db_hold = 1'b0;
   logic [31:0] word;

   serv_top #(
      .RESET_PC (RESET_PC)
   ) dut (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .o_ibus     (o_ibus),
      .o_dbus     (o_dbus)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rd, rs1);
      return {imm, rs1, 3'b000, rd, 7'h13};
   endfunction

   function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, 7'h37};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs1, rs2);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] off, input logic ne,
                                         input logic [4:0] rs1, rs2);
      return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'h63};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
   endfunction

   function automatic logic [6:0] word_index(input logic [31:0] adr);
      return 7'((adr - RESET_PC) >> 2);
   endfunction

   // ISA model, one instruction per call, returns the next PC
   function automatic logic [31:0] step_model(input logic [31:0] pc, input logic [31:0] insn,
                                              output logic st_en, output dbus_req_t st);
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [4:0]  rd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] next;
      logic        wr;
      f3    = insn[14:12];
      f7    = insn[31:25];
      rd    = insn[11:7];
      a     = xreg[insn[19:15]];
      b     = xreg[insn[24:20]];
      next  = pc + 32'd4;
      res   = '0;
      wr    = 1'b0;
      st_en = 1'b0;
      st    = '0;
      case (insn[6:0])
         OPC_OP: begin
            if (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b000)) begin
               wr = 1'b1;
               case (f3)
                  3'b000:  res = f7[5] ? a - b : a + b;
                  3'b100:  res = a ^ b;
                  3'b110:  res = a | b;
                  3'b111:  res = a & b;
                  default: wr = 1'b0;
               endcase
            end
         end
         OPC_OP_IMM: begin
            wr  = (f3 == 3'b000);
            res = a + {{20{insn[31]}}, insn[31:20]};
         end
         OPC_LUI: begin
            wr  = 1'b1;
            res = {insn[31:12], 12'h000};
         end
         OPC_STORE: begin
            st_en  = (f3 == 3'b010);
            st.adr = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
            st.dat = b;
            st.cyc = 1'b1;
         end
         OPC_BRANCH: begin
            if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
               next = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
            end
         end
         OPC_JAL: begin
            wr   = 1'b1;
            res  = pc + 32'd4;
            next = pc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
         end
         default: ;
      endcase
      if (wr && rd != 5'd0) begin
         xreg[rd] = res;
      end
      return next;
   endfunction

   task automatic record_error(input string msg);
      errors++;
      $display("%0t ns: %s", $time, msg);
   endtask

   task automatic check_ibus(input ibus_req_t exp, input ibus_req_t act);
      checks++;
      if (act.adr !== exp.adr) begin
         errors++;
         $display("** Error: o_ibus.adr = %h, expected %h", act.adr, exp.adr);
      end
   endtask

   task automatic check_dbus(input dbus_req_t exp, input dbus_req_t act);
      checks++;
      if (act.adr !== exp.adr) begin
         errors++;
         $display("** Error: o_dbus.adr = %h, expected %h", act.adr, exp.adr);
      end
      if (act.dat !== exp.dat) begin
         errors++;
         $display("** Error: o_dbus.dat = %h, expected %h", act.dat, exp.dat);
      end
   endtask

   task automatic put(input logic [31:0] w);
      imem[n_words] = w;
      n_words++;
   endtask

   task automatic start_test(input string name);
      test_name[n_tests]  = name;
      test_start[n_tests] = n_words;
      n_tests++;
   endtask

   task automatic alu_store(input logic [6:0] f7, input logic [2:0] f3,
                            input logic [4:0] rs1, rs2, input logic [11:0] adr);
      put(enc_r(f7, f3, 5'd4, rs1, rs2));
      put(enc_s(adr, 5'd0, 5'd4));
   endtask

   task automatic finish_test();
      $display("%s: %0d errors", test_name[cur_test], errors - err_mark);
      err_mark = errors;
   endtask

   task automatic build_program();
      int          kind;
      logic [31:0] r;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      // x1..x7 get values first, the register file has no reset
      start_test("reset_and_immediates");
      put(enc_i(12'h123, 5'd1, 5'd0));
      put(enc_i(12'hffb, 5'd2, 5'd0));
      put(enc_u(20'h80001, 5'd3));
      put(enc_i(12'h7ff, 5'd4, 5'd0));
      put(enc_i(12'h800, 5'd5, 5'd2));
      put(enc_u(20'hfffff, 5'd6));
      put(enc_i(12'h0f0, 5'd7, 5'd3));
      put(enc_i(12'h055, 5'd0, 5'd1));
      put(enc_s(12'h004, 5'd1, 5'd0));
      put(enc_s(12'h000, 5'd0, 5'd2));
      put(enc_s(12'hffc, 5'd1, 5'd3));
      put(enc_s(12'h008, 5'd0, 5'd5));
      put(enc_s(12'h00c, 5'd0, 5'd6));
      put(enc_s(12'h010, 5'd0, 5'd7));
      start_test("alu_ops");
      alu_store(7'h00, 3'b000, 5'd1, 5'd2, 12'h020);
      alu_store(7'h20, 3'b000, 5'd1, 5'd2, 12'h024);
      alu_store(7'h20, 3'b000, 5'd2, 5'd3, 12'h028);
      alu_store(7'h00, 3'b111, 5'd3, 5'd2, 12'h02c);
      alu_store(7'h00, 3'b110, 5'd1, 5'd3, 12'h030);
      alu_store(7'h00, 3'b100, 5'd2, 5'd6, 12'h034);
      start_test("branches");
      put(enc_b(13'd8, 1'b0, 5'd1, 5'd1));
      put(enc_i(12'h001, 5'd1, 5'd0));
      put(enc_b(13'd8, 1'b1, 5'd1, 5'd1));
      put(enc_b(13'd8, 1'b1, 5'd1, 5'd2));
      put(enc_i(12'h001, 5'd2, 5'd0));
      put(enc_b(13'd8, 1'b0, 5'd1, 5'd2));
      put(enc_b(13'd8, 1'b0, 5'd0, 5'd0));
      put(enc_i(12'h001, 5'd3, 5'd0));
      start_test("jal_link");
      put(enc_j(21'd8, 5'd6));
      put(enc_i(12'h000, 5'd6, 5'd0));
      put(enc_s(12'h014, 5'd0, 5'd6));
      put(enc_j(21'd8, 5'd0));
      put(enc_i(12'h000, 5'd7, 5'd0));
      put(enc_s(12'h018, 5'd0, 5'd7));
      start_test("random");
      for (int i = 0; i < 40; i++) begin
         kind = {$random(seed)} % 11;
         r    = $random(seed);
         rd   = 5'({$random(seed)} % 8);
         rs1  = 5'({$random(seed)} % 8);
         rs2  = 5'({$random(seed)} % 8);
         case (kind)
            0:       put(enc_r(7'h00, 3'b000, rd, rs1, rs2));
            1:       put(enc_r(7'h20, 3'b000, rd, rs1, rs2));
            2:       put(enc_r(7'h00, 3'b111, rd, rs1, rs2));
            3:       put(enc_r(7'h00, 3'b110, rd, rs1, rs2));
            4:       put(enc_r(7'h00, 3'b100, rd, rs1, rs2));
            5:       put(enc_i(r[11:0], rd, rs1));
            6:       put(enc_u(r[31:12], rd));
            7:       put(enc_s(r[11:0], rs1, rs2));
            8:       put(enc_b(13'd8, 1'b0, rs1, rs2));
            9:       put(enc_b(13'd8, 1'b1, rs1, rs2));
            default: put(enc_j(21'd8, rd));
         endcase
      end
      // Two halt words, a final forward jump may land on either
      put(HALT);
      put(HALT);
   endtask

   // Bus responders share one process to keep the random sequence fixed
   always @(posedge clk) begin
      #1;
      i_ibus_ack = 1'b0;
      i_dbus_ack = 1'b0;
      if (o_ibus.cyc === 1'b1) begin
         if (ib_delay < 0) begin
            ib_delay = {$random(seed)} % 4;
         end
         if (ib_delay == 0) begin
            i_ibus_ack = 1'b1;
            i_ibus_rdt = imem[word_index(o_ibus.adr)];
            ib_delay   = -1;
         end else begin
            ib_delay--;
         end
      end
      if (o_dbus.cyc === 1'b1) begin
         if (db_delay < 0) begin
            db_delay = {$random(seed)} % 4;
         end
         if (db_delay == 0) begin
            i_dbus_ack = 1'b1;
            db_delay   = -1;
         end else begin
            db_delay--;
         end
      end
   end

   // Compare process, samples mid-cycle
   always @(negedge clk) begin
      if (i_rst_n && !done) begin
         if (ib_hold && o_ibus.cyc !== 1'b1) begin
            record_error("instruction request dropped before its ack");
         end else if (ib_hold && o_ibus.adr !== prev_ib.adr) begin
            errors++;
            $display("** Error: o_ibus.adr = %h while waiting, was %h", o_ibus.adr, prev_ib.adr);
         end
         if (db_hold && o_dbus.cyc !== 1'b1) begin
            record_error("store request dropped before its ack");
         end else if (db_hold && o_dbus !== prev_db) begin
            errors++;
            $display("** Error: o_dbus = %h while waiting, was %h", o_dbus, prev_db);
         end
         ib_hold = o_ibus.cyc && !i_ibus_ack;
         db_hold = o_dbus.cyc && !i_dbus_ack;
         prev_ib = o_ibus;
         prev_db = o_dbus;
         if (o_dbus.cyc && i_dbus_ack) begin
            if (!store_pend) begin
               record_error("store issued where the model has none");
            end else begin
               check_dbus(exp_st, o_dbus);
            end
            store_pend = 1'b0;
         end
         if (o_ibus.cyc && i_ibus_ack) begin
            if (store_pend) begin
               record_error("expected store missing before the next fetch");
               store_pend = 1'b0;
            end
            exp_ib.adr = ref_pc;
            exp_ib.cyc = 1'b1;
            check_ibus(exp_ib, o_ibus);
            if (cur_test + 1 < n_tests && word_index(ref_pc) >= test_start[cur_test + 1]) begin
               finish_test();
               cur_test++;
            end
            word = imem[word_index(ref_pc)];
            if (word == HALT) begin
               finish_test();
               done = 1'b1;
            end else begin
               ref_pc = step_model(ref_pc, word, store_pend, exp_st);
            end
         end
      end
   end

   // Watchdog, a branch needs two passes plus fetch and ack slack
   initial begin
      wait (built);
      repeat (n_words * (2 * 32 + 8) + 100) @(posedge clk);
      $display("watchdog: halt address not fetched in time, run stopped");
      $display("Test FAILED");
      $finish;
   end

   initial begin
      seed       = 32'h3f25;
      i_rst_n    = 1'b0;
      i_ibus_rdt = 32'h0;
      i_ibus_ack = 1'b0;
      i_dbus_ack = 1'b0;
      for (int i = 0; i < 32; i++) begin
         xreg[i] = 32'h0;
      end
      build_program();
      built = 1'b1;
      @(posedge clk);
      @(negedge clk);
      if (o_ibus.cyc !== 1'b0 || o_dbus.cyc !== 1'b0) begin
         record_error("bus request active during reset");
      end
      @(posedge clk);
      #1 i_rst_n = 1'b1;
      @(posedge clk);
      @(negedge clk);
      if (o_ibus.cyc !== 1'b1) begin
         record_error("no fetch in the first cycle after reset");
      end
      wait (done);
      $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
hdl/serv_isa_pkg.sv
hdl/serv_bus_pkg.sv
hdl/serv_state.sv
hdl/serv_decode.sv
hdl/serv_alu.sv
hdl/serv_rf.sv
hdl/serv_ctrl.sv
hdl/serv_lsu.sv
hdl/serv_top.sv
verif/serv_tb.sv
